//--- design/ColorBufferPkg.sv
`default_nettype none

package ColorBufferPkg;

    // one square tile of the frame is kept on chip at a time
    localparam int TILE_DIM      = 16;
    localparam int PIXEL_COUNT   = TILE_DIM * TILE_DIM;   // 256 pixels per tile
    localparam int ADDR_BITS     = $clog2(PIXEL_COUNT);   // linear address, row major

    // RGBA4444 layout with red in the top nibble and alpha in the bottom one
    localparam int CHANNEL_BITS  = 4;
    localparam int CHANNEL_COUNT = 4;

    typedef logic [CHANNEL_BITS*CHANNEL_COUNT-1:0] pixel_t;
    typedef logic [ADDR_BITS-1:0]                  pixelAddr_t;

    // bit 0 enables alpha (lowest nibble) and bit 3 enables red
    typedef logic [CHANNEL_COUNT-1:0]              channelMask_t;

    // replace overwrites the channel while add saturates at the channel maximum
    typedef enum logic
    {
        BLEND_REPLACE,
        BLEND_ADD
    } blendMode_t;

    typedef enum logic
    {
        BLEND_IDLE,     // port A reads the incoming fragment's address
        BLEND_WRITE     // old pixel is on writeDataOut and the merge is written back
    } blendState_t;

    typedef enum logic [1:0]
    {
        FLUSH_IDLE,
        FLUSH_SWEEP,    // one address per cycle goes out on port B
        FLUSH_DRAIN     // last pixel leaves the pipeline here
    } flushState_t;

endpackage

`default_nettype wire

//--- design/RamWritePortIf.sv
`timescale 1ns/100ps
`default_nettype none

// port A of the tile RAM, which writes and also returns the old word
interface RamWritePortIf import ColorBufferPkg::*; ();

    pixel_t       writeData;     // word to store, only masked channels land
    logic         write;         // write strobe for this cycle
    pixelAddr_t   writeAddr;     // shared by the read and the write of port A
    channelMask_t writeMask;     // per nibble write enable
    pixel_t       writeDataOut;  // word at the address of the previous edge, before any write there

    // the blender owns the request side of the port
    modport blender
    (
        output writeData,
        output write,
        output writeAddr,
        output writeMask,
        input  writeDataOut
    );

    modport ram
    (
        input  writeData,
        input  write,
        input  writeAddr,
        input  writeMask,
        output writeDataOut
    );

endinterface

`default_nettype wire

//--- design/TrueDualPortRam.sv
`timescale 1ns/100ps
`default_nettype none

// dual port tile memory with a read-first data output on the write port
module TrueDualPortRam import ColorBufferPkg::*;
#(
    parameter int ADDR_WIDTH = ADDR_BITS   // depth is 2**ADDR_WIDTH words
)
(
    input  logic        clk,
    input  logic        reset,
    RamWritePortIf.ram  wp,
    input  pixelAddr_t  readAddr,
    output pixel_t      readData
);

    localparam int DEPTH = 2 ** ADDR_WIDTH;

    pixel_t mem [DEPTH];

    pixel_t writeMemOut;   // registered port A output
    pixel_t readMemOut;    // registered port B output

    logic [ADDR_WIDTH-1:0] portAAddr;
    logic [ADDR_WIDTH-1:0] portBAddr;

    assign portAAddr = wp.writeAddr[ADDR_WIDTH-1:0];
    assign portBAddr = readAddr[ADDR_WIDTH-1:0];

    // nibble wide write enables, each mask bit owns one color channel
    always_ff @(posedge clk)
    begin
        if (wp.write)
        begin
            for (int ch = 0; ch < CHANNEL_COUNT; ch++)
            begin
                if (wp.writeMask[ch])
                    mem[portAAddr][ch*CHANNEL_BITS +: CHANNEL_BITS] <=
                        wp.writeData[ch*CHANNEL_BITS +: CHANNEL_BITS];
            end
        end
    end

    // the nonblocking reads see the array before this edge's write, so both ports are read-first
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            writeMemOut <= '0;
            readMemOut  <= '0;
        end
        else
        begin
            writeMemOut <= mem[portAAddr];   // old word, lets the blender modify it
            readMemOut  <= mem[portBAddr];   // flush side, one cycle latency
        end
    end

    assign wp.writeDataOut = writeMemOut;
    assign readData        = readMemOut;

endmodule

`default_nettype wire

//--- design/FragmentBlender.sv
`timescale 1ns/100ps
`default_nettype none

// takes one fragment every second cycle and merges it into the tile over port A
module FragmentBlender import ColorBufferPkg::*;
(
    input  logic            clk,
    input  logic            reset,
    input  logic            fragValid,
    input  pixelAddr_t      fragAddr,
    input  pixel_t          fragColor,
    input  channelMask_t    fragMask,
    input  blendMode_t      fragMode,
    output logic            blendBusy,
    RamWritePortIf.blender  wp
);

    blendState_t  state;
    logic         accept;         // fragment taken at this edge

    // fragment held across the read-modify-write
    pixelAddr_t   addrReg;
    pixel_t       colorReg;
    channelMask_t maskReg;
    blendMode_t   modeReg;

    pixel_t       blendedPixel;   // merge of the old word and the held fragment

    // one channel of the blend, the add clamps at the largest channel value
    function automatic logic [CHANNEL_BITS-1:0] blendChannel
    (
        input logic [CHANNEL_BITS-1:0] oldValue,
        input logic [CHANNEL_BITS-1:0] fragValue,
        input blendMode_t              mode
    );
        logic [CHANNEL_BITS:0] sum;   // one spare bit catches the overflow
        sum = {1'b0, oldValue} + {1'b0, fragValue};
        if (mode == BLEND_REPLACE)
            return fragValue;
        if (sum[CHANNEL_BITS])
            return '1;   // saturate
        return sum[CHANNEL_BITS-1:0];
    endfunction

    assign accept = (state == BLEND_IDLE) && fragValid;   // anything arriving while busy is lost

    always_ff @(posedge clk)
    begin
        if (reset)
            state <= BLEND_IDLE;
        else
        begin
            case (state)
                BLEND_IDLE:
                begin
                    if (accept)
                        state <= BLEND_WRITE;
                end
                BLEND_WRITE:
                    state <= BLEND_IDLE;   // the write always finishes in one cycle
                default:
                    state <= BLEND_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            addrReg  <= fragAddr;
            colorReg <= fragColor;
            maskReg  <= fragMask;
            modeReg  <= fragMode;
        end
    end

    // channels outside the mask carry the old value, though the RAM ignores them anyway
    always_comb
    begin
        for (int ch = 0; ch < CHANNEL_COUNT; ch++)
        begin
            if (maskReg[ch])
                blendedPixel[ch*CHANNEL_BITS +: CHANNEL_BITS] = blendChannel(
                    wp.writeDataOut[ch*CHANNEL_BITS +: CHANNEL_BITS],
                    colorReg[ch*CHANNEL_BITS +: CHANNEL_BITS],
                    modeReg);
            else
                blendedPixel[ch*CHANNEL_BITS +: CHANNEL_BITS] =
                    wp.writeDataOut[ch*CHANNEL_BITS +: CHANNEL_BITS];
        end
    end

    // while idle the incoming address goes straight to the RAM so the old word is ready next cycle
    assign wp.writeAddr  = (state == BLEND_WRITE) ? addrReg : fragAddr;
    assign wp.write      = (state == BLEND_WRITE);
    assign wp.writeData  = blendedPixel;
    assign wp.writeMask  = maskReg;
    assign blendBusy     = (state == BLEND_WRITE);   // high only in the write cycle

endmodule

`default_nettype wire

//--- design/TileStreamer.sv
`timescale 1ns/100ps
`default_nettype none

// sweeps port B over the whole tile once per flush and streams the pixels out
module TileStreamer import ColorBufferPkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       flushStart,
    output pixelAddr_t readAddr,
    input  pixel_t     readData,
    output logic       pixelValid,
    output pixelAddr_t pixelIndex,
    output pixel_t     pixelData,
    output logic       flushBusy,
    output logic       flushDone
);

    flushState_t state;
    pixelAddr_t  addrCount;   // address on port B during the sweep
    logic        issue;       // a read goes to the RAM at the coming edge
    logic        lastAddr;

    assign issue    = (state == FLUSH_SWEEP);
    assign lastAddr = (addrCount == pixelAddr_t'(PIXEL_COUNT - 1));

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state     <= FLUSH_IDLE;
            addrCount <= '0;
        end
        else
        begin
            case (state)
                FLUSH_IDLE:
                begin
                    // the done cycle still counts as busy, so no restart there
                    if (flushStart && !flushDone)
                    begin
                        state     <= FLUSH_SWEEP;
                        addrCount <= '0;
                    end
                end
                FLUSH_SWEEP:
                begin
                    addrCount <= addrCount + 1'b1;   // wraps back to zero after the last pixel
                    if (lastAddr)
                        state <= FLUSH_DRAIN;
                end
                FLUSH_DRAIN:
                    state <= FLUSH_IDLE;   // last pixel is on the outputs in this cycle
                default:
                    state <= FLUSH_IDLE;
            endcase
        end
    end

    // the valid flag and the index follow the address by the RAM latency of one cycle
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            pixelValid <= 1'b0;
            flushDone  <= 1'b0;
        end
        else
        begin
            pixelValid <= issue;
            flushDone  <= (state == FLUSH_DRAIN);   // pulse one cycle after the last pixel
        end
    end

    always_ff @(posedge clk)
    begin
        pixelIndex <= addrCount;
    end

    assign readAddr  = addrCount;
    assign pixelData = readData;   // already registered inside the RAM
    assign flushBusy = (state != FLUSH_IDLE) || flushDone;

endmodule

`default_nettype wire

//--- design/ColorBufferTop.sv
`timescale 1ns/100ps
`default_nettype none

// on chip color buffer for one tile with a fragment input and a flush stream out
module ColorBufferTop import ColorBufferPkg::*;
(
    input  logic         clk,
    input  logic         reset,

    // fragments, one every second cycle at most
    input  logic         fragValid,
    input  pixelAddr_t   fragAddr,
    input  pixel_t       fragColor,
    input  channelMask_t fragMask,
    input  blendMode_t   fragMode,
    output logic         blendBusy,

    // flush request and the resulting pixel stream, no back-pressure
    input  logic         flushStart,
    output logic         pixelValid,
    output pixelAddr_t   pixelIndex,
    output pixel_t       pixelData,
    output logic         flushBusy,
    output logic         flushDone
);

    RamWritePortIf ramPortA ();   // blender side of the RAM

    pixelAddr_t readAddr;         // flush side of the RAM
    pixel_t     readData;

    FragmentBlender i_FragmentBlender
    (
        .clk       (clk),
        .reset     (reset),
        .fragValid (fragValid),
        .fragAddr  (fragAddr),
        .fragColor (fragColor),
        .fragMask  (fragMask),
        .fragMode  (fragMode),
        .blendBusy (blendBusy),
        .wp        (ramPortA.blender)
    );

    // depth follows the tile size
    TrueDualPortRam #(
        .ADDR_WIDTH (ADDR_BITS)
    ) i_TrueDualPortRam
    (
        .clk      (clk),
        .reset    (reset),
        .wp       (ramPortA.ram),
        .readAddr (readAddr),
        .readData (readData)
    );

    TileStreamer i_TileStreamer
    (
        .clk        (clk),
        .reset      (reset),
        .flushStart (flushStart),
        .readAddr   (readAddr),
        .readData   (readData),
        .pixelValid (pixelValid),
        .pixelIndex (pixelIndex),
        .pixelData  (pixelData),
        .flushBusy  (flushBusy),
        .flushDone  (flushDone)
    );

endmodule

`default_nettype wire

//--- verif/ClockGen.sv
`timescale 1ns/100ps
`default_nettype none

// free running testbench clock and a reset that covers the first three rising edges
module ClockGen
(
    output logic clk,
    output logic reset
);

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;   // 100 ns period
    end

    initial
    begin
        reset = 1'b1;
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;   // released on a falling edge like every other DUT input
    end

endmodule

`default_nettype wire

//--- verif/ColorBufferTb.sv
`timescale 1ns/100ps
`default_nettype none

// reads the stimulus file, drives fragments and flushes, and checks every flushed pixel
module ColorBufferTb import ColorBufferPkg::*; ();

    logic         clk;
    logic         reset;
    logic         fragValid;
    pixelAddr_t   fragAddr;
    pixel_t       fragColor;
    channelMask_t fragMask;
    blendMode_t   fragMode;
    logic         blendBusy;
    logic         flushStart;
    logic         pixelValid;
    pixelAddr_t   pixelIndex;
    pixel_t       pixelData;
    logic         flushBusy;
    logic         flushDone;

    pixel_t       model [PIXEL_COUNT];      // expected tile contents
    pixel_t       captured [PIXEL_COUNT];   // pixels seen in the last flush
    logic [15:0]  lfsrState = 16'd44399;
    int           errorCount = 0;
    int           testErrors = 0;
    int           testCount = 0;
    int           cycleCount = 0;
    int           cycleLimit = 1000;        // raised once the stimulus file has been sized
    logic         testOpen = 1'b0;
    string        testName;

    ClockGen i_ClockGen (.clk(clk), .reset(reset));

    ColorBufferTop i_ColorBufferTop
    (
        .clk(clk), .reset(reset),
        .fragValid(fragValid), .fragAddr(fragAddr), .fragColor(fragColor),
        .fragMask(fragMask), .fragMode(fragMode), .blendBusy(blendBusy),
        .flushStart(flushStart), .pixelValid(pixelValid), .pixelIndex(pixelIndex),
        .pixelData(pixelData), .flushBusy(flushBusy), .flushDone(flushDone)
    );

    always @(posedge clk)
    begin
        cycleCount <= cycleCount + 1;
        if (cycleCount > cycleLimit)
        begin
            $display("timeout after %0d cycles, the DUT never finished a request", cycleCount);
            $display("Result: FAILED");
            $finish;
        end
    end

    // works channel by channel where unmasked ones keep the old nibble and add clamps at 15
    function automatic pixel_t expectBlend(pixel_t old, pixel_t frag, channelMask_t mask,
                                           blendMode_t mode);
        pixel_t result;
        int     sum;
        result = old;
        for (int ch = 0; ch < CHANNEL_COUNT; ch++)
        begin
            sum = int'(frag[4*ch +: 4]);
            if (mode == BLEND_ADD)
                sum = sum + int'(old[4*ch +: 4]);
            if (sum > 15)
                sum = 15;
            if (mask[ch])
                result[4*ch +: 4] = sum[3:0];
        end
        return result;
    endfunction

    // Galois form with taps x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsrNext(logic [15:0] s);
        if (s[0])
            return (s >> 1) ^ 16'hB400;
        return s >> 1;
    endfunction

    task automatic drawBits(input int count, output logic [15:0] value);
        value = '0;
        for (int i = 0; i < count; i++)
        begin
            value     = {value[14:0], lfsrState[0]};   // one step per bit taken
            lfsrState = lfsrNext(lfsrState);
        end
    endtask

    task automatic countError();
        errorCount++;
        testErrors++;
    endtask

    task automatic closeTest();
        if (testOpen)
        begin
            $display("test %0s finished with %0d errors", testName, testErrors);
            testCount++;
        end
        testOpen   = 1'b0;
        testErrors = 0;
    endtask

    task automatic checkLow(input string name, input logic value, input string when);
        if (value !== 1'b0)
        begin
            $display("ERR %0s %0s: got 0x%0h expected 0x0", name, when, value);
            countError();
        end
    endtask

    // dropNext keeps fragValid high through the busy cycle with other fields, which must be lost
    task automatic driveFragment(input pixelAddr_t addr, input pixel_t color,
                                 input channelMask_t mask, input blendMode_t mode,
                                 input logic dropNext, input pixel_t dropColor,
                                 input channelMask_t dropMask, input blendMode_t dropMode);
        @(negedge clk);
        while (blendBusy)
            @(negedge clk);
        fragValid = 1'b1;
        fragAddr  = addr;
        fragColor = color;
        fragMask  = mask;
        fragMode  = mode;
        @(negedge clk);
        if (blendBusy !== 1'b1)
        begin
            $display("ERR blendBusy after fragment 0x%02h: got 0x%0h expected 0x1",
                     addr, blendBusy);
            countError();
        end
        if (dropNext)
        begin
            fragColor = dropColor;
            fragMask  = dropMask;
            fragMode  = dropMode;
            @(negedge clk);
            if (blendBusy !== 1'b0)   // busy lasts one cycle and the dropped fragment starts nothing
            begin
                $display("ERR blendBusy after dropped fragment: got 0x%0h expected 0x0",
                         blendBusy);
                countError();
            end
        end
        fragValid   = 1'b0;
        model[addr] = expectBlend(model[addr], color, mask, mode);
    endtask

    task automatic randomFragment();
        logic [15:0] addr;
        logic [15:0] color;
        logic [15:0] mask;
        logic [15:0] mode;
        drawBits(ADDR_BITS, addr);
        drawBits(16, color);
        drawBits(CHANNEL_COUNT, mask);
        drawBits(1, mode);
        driveFragment(addr[7:0], color, mask[3:0], blendMode_t'(mode[0]),
                      1'b0, '0, '0, BLEND_REPLACE);
    endtask

    // extraStart raises flushStart again in mid sweep and in the done cycle and both are ignored
    task automatic runFlush(input logic extraStart);
        int   count;
        logic prevValid;
        logic doneSeen;
        count     = 0;
        prevValid = 1'b0;
        doneSeen  = 1'b0;
        for (int i = 0; i < PIXEL_COUNT; i++)
            captured[i] = 'x;
        @(negedge clk);
        flushStart = 1'b1;
        @(negedge clk);
        flushStart = 1'b0;
        while (!doneSeen)
        begin
            if (flushBusy !== 1'b1)   // busy from the cycle after the start through the done cycle
            begin
                $display("ERR flushBusy during flush: got 0x%0h expected 0x1", flushBusy);
                countError();
            end
            if (pixelValid)
            begin
                if (pixelIndex !== pixelAddr_t'(count))
                begin
                    $display("ERR pixelIndex: got 0x%02h expected 0x%02h",
                             pixelIndex, count[7:0]);
                    countError();
                end
                captured[pixelIndex] = pixelData;
                count++;
            end
            if (flushDone)
            begin
                doneSeen = 1'b1;
                if (!prevValid || pixelValid || count != PIXEL_COUNT)
                begin
                    $display("flushDone did not come in the cycle after the last pixel");
                    countError();
                end
            end
            flushStart = extraStart && (count == 100 || doneSeen);
            prevValid  = pixelValid;
            @(negedge clk);
        end
        flushStart = 1'b0;
        repeat (3)
        begin
            checkLow("pixelValid", pixelValid, "after flush");
            checkLow("flushDone", flushDone, "after flush");
            checkLow("flushBusy", flushBusy, "after flush");
            @(negedge clk);
        end
        if (count != PIXEL_COUNT)
        begin
            $display("flush delivered %0d pixels instead of %0d", count, PIXEL_COUNT);
            countError();
        end
        for (int i = 0; i < PIXEL_COUNT; i++)
        begin
            if (captured[i] !== model[i])
            begin
                $display("ERR pixelData[0x%02h]: got 0x%04h expected 0x%04h",
                         i[7:0], captured[i], model[i]);
                countError();
            end
        end
    endtask

    initial
    begin
        int               fd;
        int               got;
        int               fragTotal;
        int               flushTotal;
        logic [8*128-1:0] lineBuf;
        logic [8*32-1:0]  tok;
        logic [8*32-1:0]  nameBuf;
        logic [15:0]      a1;
        logic [15:0]      a2;
        logic [15:0]      a3;
        logic [15:0]      a4;

        fragValid  = 1'b0;
        fragAddr   = '0;
        fragColor  = '0;
        fragMask   = '0;
        fragMode   = BLEND_REPLACE;
        flushStart = 1'b0;
        fragTotal  = 0;
        flushTotal = 0;

        // first pass only sizes the run for the timeout
        fd = $fopen("verif/colorBufferStim.txt", "r");
        if (fd == 0)
        begin
            $display("could not open the stimulus file verif/colorBufferStim.txt");
            countError();
        end
        else
        begin
            while (!$feof(fd))
            begin
                lineBuf = '0;
                tok     = '0;
                a1      = '0;
                got     = $fgets(lineBuf, fd);
                got     = $sscanf(lineBuf, "%s %h", tok, a1);
                if (tok == "F" || tok == "D")
                    fragTotal++;
                else if (tok == "P")
                    fragTotal += PIXEL_COUNT;
                else if (tok == "R")
                    fragTotal += int'(a1);
                else if (tok == "S")
                    flushTotal++;
            end
            $fclose(fd);
            cycleLimit = 2 * fragTotal + 260 * flushTotal + 200;
        end

        @(negedge clk);
        while (reset)
            @(negedge clk);
        testName = "reset";
        testOpen = 1'b1;
        checkLow("pixelValid", pixelValid, "after reset");
        checkLow("flushBusy", flushBusy, "after reset");
        checkLow("flushDone", flushDone, "after reset");
        checkLow("blendBusy", blendBusy, "after reset");
        closeTest();

        fd = $fopen("verif/colorBufferStim.txt", "r");
        if (fd != 0)
        begin
            while (!$feof(fd))
            begin
                lineBuf = '0;
                tok     = '0;
                nameBuf = '0;
                got     = $fgets(lineBuf, fd);
                got     = $sscanf(lineBuf, "%s %h %h %h %h", tok, a1, a2, a3, a4);
                if (tok == "T")
                begin
                    closeTest();
                    got      = $sscanf(lineBuf, "%s %s", tok, nameBuf);
                    testName = string'(nameBuf);
                    testOpen = 1'b1;
                end
                else if (tok == "F")
                    driveFragment(a1[7:0], a2, a3[3:0], blendMode_t'(a4[0]),
                                  1'b0, '0, '0, BLEND_REPLACE);
                else if (tok == "D")   // rewrite the model's own value, then try a fragment while busy
                    driveFragment(a1[7:0], model[a1[7:0]], 4'hF, BLEND_REPLACE,
                                  1'b1, a2, a3[3:0], blendMode_t'(a4[0]));
                else if (tok == "P")
                begin
                    for (int i = 0; i < PIXEL_COUNT; i++)
                        driveFragment(i[7:0], {i[7:0], i[7:0] ^ 8'hA5}, 4'hF, BLEND_REPLACE,
                                      1'b0, '0, '0, BLEND_REPLACE);
                end
                else if (tok == "R")
                begin
                    for (int i = 0; i < int'(a1); i++)
                        randomFragment();
                end
                else if (tok == "S")
                    runFlush(a1[0]);
                else if (tok == "E" && captured[a1[7:0]] !== a2)
                begin
                    $display("ERR pixelData[0x%02h]: got 0x%04h expected 0x%04h",
                             a1[7:0], captured[a1[7:0]], a2);
                    countError();
                end
            end
            $fclose(fd);
        end
        closeTest();

        $display("%0d tests run, %0d errors", testCount, errorCount);
        if (errorCount == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- verif/colorBufferStim.txt
# numbers in hex: F addr color mask mode, D addr color mask mode, E index pixel
# P fills pixel a with {a, a^A5}, R count random fragments, S extraStart flushes, T name
T fill
P
S 0
E 00 00A5
E 3C 3C99
E FF FF5A
T mask
F 10 FFFF 3 0
F 20 ABCD 8 0
F 30 0000 6 0
F 40 FFFF 0 0
S 0
E 10 10FF
E 20 A085
E 30 3005
E 40 40E5
T add
F 50 1111 F 1
F 50 8888 F 1
F 50 4444 F 1
F 60 3F3F 5 1
F 70 0000 F 0
F 70 0009 F 1
F 70 0009 1 1
S 0
E 50 FDFF
E 60 6FCF
E 70 000F
T ignored
D 80 FFFF F 0
S 1
E 80 8025
T random
R 100
S 0

//--- list.f
design/ColorBufferPkg.sv
design/RamWritePortIf.sv
design/TrueDualPortRam.sv
design/FragmentBlender.sv
design/TileStreamer.sv
design/ColorBufferTop.sv
verif/ClockGen.sv
verif/ColorBufferTb.sv

//--- run.sh
#!/bin/bash
# build with Verilator and run from the project root so the stimulus path resolves
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal -f list.f --top-module ColorBufferTb \
    --Mdir obj_dir -o ColorBufferTb > build.log 2>&1 \
    && ./obj_dir/ColorBufferTb > sim.log 2>&1 \
    || { cat build.log; echo "build or simulation did not complete"; exit 1; }
grep -q "Result: PASSED" sim.log && echo "simulation passed" \
    || { cat sim.log; echo "simulation failed"; exit 1; }
